// ==== verilog/spritePkg.sv ====
// Sprite player constants
package spritePkg;

    // Play area bounds
    localparam logic [8:0] screenXMin = 9'd1;
    localparam logic [8:0] screenXMax = 9'd319;
    localparam logic [8:0] screenYMin = 9'd0;
    localparam logic [8:0] screenYMax = 9'd239;

    // Sprite size in pixels
    localparam logic [8:0] spriteWidth  = 9'd18;
    localparam logic [8:0] spriteHeight = 9'd20;

    // Screen centre minus half the sprite
    localparam logic [8:0] startX = 9'd151;
    localparam logic [8:0] startY = 9'd110;

    localparam logic [8:0] stepX = 9'd2;   // Pixels per move
    localparam logic [8:0] stepY = 9'd2;

    localparam int framesPerMove = 4;   // Frame edges per move tick

    // Keycodes for W, S, A, D
    localparam logic [7:0] keyUp    = 8'd26;
    localparam logic [7:0] keyDown  = 8'd22;
    localparam logic [7:0] keyLeft  = 8'd4;
    localparam logic [7:0] keyRight = 8'd7;

    // Facing direction, also the pose group in sprite memory
    localparam logic [1:0] dirDown  = 2'd0;
    localparam logic [1:0] dirLeft  = 2'd1;
    localparam logic [1:0] dirUp    = 2'd2;
    localparam logic [1:0] dirRight = 2'd3;

    localparam int posesPerDir = 3;
    localparam int addrWidth   = 13;   // Sprite memory address

    // Wishbone word addresses
    localparam logic regKey    = 1'b0;
    localparam logic regStatus = 1'b1;

endpackage

// ==== verilog/playerStateIf.sv ====
// Player state bundle
`timescale 1ns/1ps

interface playerStateIf;

    logic [8:0] xPos;        // Upper left corner
    logic [8:0] yPos;
    logic [1:0] direction;
    logic [1:0] stepCount;   // Walk animation step

    modport owner (
        output xPos,
        output yPos,
        output direction,
        output stepCount
    );

    modport viewer (
        input xPos,
        input yPos,
        input direction,
        input stepCount
    );

endinterface

// ==== verilog/frameTick.sv ====
// Move tick generator
`timescale 1ns/1ps

module frameTick (
    input  logic Clk,
    input  logic reset,
    input  logic frameClk,   // Slow frame clock from video timing
    output logic moveTick
);

    logic frameClkQ;
    logic frameRise;
    logic [1:0] frameCount;

    // Previous frameClk sample for edge detection
    always_ff @(posedge Clk)
        frameClkQ <= frameClk;

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            frameRise  <= 1'b0;
            frameCount <= 2'd0;
            moveTick   <= 1'b0;
        end
        else
        begin
            frameRise <= frameClk && !frameClkQ;
            moveTick  <= 1'b0;
            if (frameRise)
            begin
                if (frameCount == 2'(spritePkg::framesPerMove - 1))
                begin
                    frameCount <= 2'd0;
                    moveTick   <= 1'b1;   // Every fourth frame
                end
                else
                    frameCount <= frameCount + 2'd1;
            end
        end
    end

    tickSingle: assert property (@(posedge Clk) disable iff (reset) moveTick |=> !moveTick);

endmodule

// ==== verilog/playerMotion.sv ====
// Player movement and walk animation
`timescale 1ns/1ps

module playerMotion (
    input  logic        Clk,
    input  logic        reset,
    input  logic        moveTick,
    input  logic [7:0]  keycode,
    playerStateIf.owner state
);

    logic [8:0] xNext;
    logic [8:0] yNext;
    logic [1:0] dirNext;
    logic       moving;

    always_comb
    begin
        // Hold by default
        xNext   = state.xPos;
        yNext   = state.yPos;
        dirNext = state.direction;
        moving  = 1'b0;

        case (keycode)
            spritePkg::keyUp:
            begin
                dirNext = spritePkg::dirUp;
                if (state.yPos > spritePkg::screenYMin)
                begin
                    yNext  = state.yPos - spritePkg::stepY;
                    moving = 1'b1;
                end
            end
            spritePkg::keyDown:
            begin
                dirNext = spritePkg::dirDown;
                // Bottom edge of the sprite against the lower bound
                if ({1'b0, state.yPos} + spritePkg::spriteHeight < {1'b0, spritePkg::screenYMax})
                begin
                    yNext  = state.yPos + spritePkg::stepY;
                    moving = 1'b1;
                end
            end
            spritePkg::keyLeft:
            begin
                dirNext = spritePkg::dirLeft;
                if (state.xPos > spritePkg::screenXMin)
                begin
                    xNext  = state.xPos - spritePkg::stepX;
                    moving = 1'b1;
                end
            end
            spritePkg::keyRight:
            begin
                dirNext = spritePkg::dirRight;
                if ({1'b0, state.xPos} + spritePkg::spriteWidth < {1'b0, spritePkg::screenXMax})
                begin
                    xNext  = state.xPos + spritePkg::stepX;
                    moving = 1'b1;
                end
            end
            default:
            begin
                moving = 1'b0;   // Unknown key, stand still
            end
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            state.xPos      <= spritePkg::startX;
            state.yPos      <= spritePkg::startY;
            state.direction <= spritePkg::dirDown;
            state.stepCount <= 2'd0;
        end
        else if (moveTick)
        begin
            state.xPos      <= xNext;
            state.yPos      <= yNext;
            state.direction <= dirNext;
            // Walk cycle restarts whenever the player stops
            state.stepCount <= moving ? state.stepCount + 2'd1 : 2'd0;
        end
    end

    xInBounds: assert property (@(posedge Clk) disable iff (reset)
        (state.xPos >= spritePkg::screenXMin) && (state.xPos <= spritePkg::screenXMax));

endmodule

// ==== verilog/spriteAddrGen.sv ====
// Sprite hit test and address
`timescale 1ns/1ps

module spriteAddrGen (
    input  logic        Clk,
    input  logic        reset,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    playerStateIf.viewer state,
    output logic        objHit,
    output logic [spritePkg::addrWidth-1:0] objAddr
);

    localparam int aw = spritePkg::addrWidth;

    logic           hit;
    logic [3:0]     poseIdx;
    logic [aw-1:0]  colOff;
    logic [aw-1:0]  rowOff;
    logic [aw-1:0]  poseBase;
    logic [aw-1:0]  addrNext;

    // Inside the sprite box, right and bottom edges exclusive
    assign hit = ({1'b0, pixelX} >= {1'b0, state.xPos}) &&
                 ({1'b0, pixelX} <  {1'b0, state.xPos} + spritePkg::spriteWidth) &&
                 ({1'b0, pixelY} >= {1'b0, state.yPos}) &&
                 ({1'b0, pixelY} <  {1'b0, state.yPos} + spritePkg::spriteHeight);

    always_comb
    begin
        // Even steps show the standing pose, odd steps alternate the two strides
        poseIdx = 4'(spritePkg::posesPerDir * state.direction);
        if (state.stepCount[0])
            poseIdx = poseIdx + 4'd1 + {3'b0, state.stepCount[1]};

        colOff   = {{(aw-9){1'b0}}, pixelX - state.xPos};
        rowOff   = {{(aw-9){1'b0}}, pixelY - state.yPos};
        poseBase = spritePkg::spriteWidth * spritePkg::spriteHeight * {{(aw-4){1'b0}}, poseIdx};
        addrNext = colOff + rowOff * spritePkg::spriteWidth + poseBase;
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            objHit  <= 1'b0;
            objAddr <= '0;
        end
        else
        begin
            objHit  <= hit;
            objAddr <= hit ? addrNext : '0;   // Background reads as zero
        end
    end

    missHasNoAddr: assert property (@(posedge Clk) disable iff (reset) !objHit |-> objAddr == '0);

endmodule

// ==== verilog/wbKeyPort.sv ====
// Wishbone keycode and status port
`timescale 1ns/1ps

module wbKeyPort (
    input  logic        Clk,
    input  logic        reset,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic        wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck,
    output logic [7:0]  keycode,
    playerStateIf.viewer state
);

    logic        request;
    logic [31:0] statusWord;

    // New request only while ack is low, so a held cycle acks every other clock
    assign request = wbCyc && wbStb && !wbAck;

    assign statusWord = {10'b0, state.stepCount, state.direction, state.yPos, state.xPos};

    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            wbAck   <= 1'b0;
            keycode <= 8'd0;
        end
        else
        begin
            wbAck <= request;
            if (request && wbWe && (wbAdr == spritePkg::regKey))
                keycode <= wbDatW[7:0];   // Status writes are dropped
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge Clk)
    begin
        if (request)
        begin
            if (wbAdr == spritePkg::regStatus)
                wbDatR <= statusWord;
            else
                wbDatR <= {24'b0, keycode};
        end
    end

    ackFollowsRequest: assert property (@(posedge Clk) disable iff (reset)
        wbAck |-> $past(wbCyc && wbStb));

endmodule

// ==== verilog/playerTop.sv ====
// Sprite player top level
`timescale 1ns/1ps

module playerTop (
    input  logic        Clk,
    input  logic        reset,
    input  logic        frameClk,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic        wbAdr,
    input  logic [31:0] wbDatW,
    output logic [31:0] wbDatR,
    output logic        wbAck,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    output logic        objHit,
    output logic [12:0] objAddr
);

    logic       moveTick;
    logic [7:0] keycode;

    playerStateIf playerState ();

    frameTick tickGen (
        .Clk      (Clk),
        .reset    (reset),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    playerMotion motion (
        .Clk      (Clk),
        .reset    (reset),
        .moveTick (moveTick),
        .keycode  (keycode),
        .state    (playerState.owner)
    );

    spriteAddrGen addrGen (
        .Clk     (Clk),
        .reset   (reset),
        .pixelX  (pixelX),
        .pixelY  (pixelY),
        .state   (playerState.viewer),
        .objHit  (objHit),
        .objAddr (objAddr)
    );

    wbKeyPort keyPort (
        .Clk     (Clk),
        .reset   (reset),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbDatR  (wbDatR),
        .wbAck   (wbAck),
        .keycode (keycode),
        .state   (playerState.viewer)
    );

endmodule

// ==== test/playerChecker.sv ====
// Player reference model and checks
`timescale 1ns/1ps

module playerChecker (
    input  logic        Clk,
    input  logic        reset,
    input  logic        frameClk,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic        wbAdr,
    input  logic [31:0] wbDatW,
    input  logic [31:0] wbDatR,
    input  logic        wbAck,
    input  logic [8:0]  pixelX,
    input  logic [8:0]  pixelY,
    input  logic        objHit,
    input  logic [12:0] objAddr,
    output int          errorCount
);

    int x;
    int y;
    int dir;
    int step;
    int key;
    int rises;       // Frame edges since the last move
    int sinceRise;   // Clocks since the last frame edge
    int pose;
    int expAddr;
    logic expHit;
    logic expValid;
    logic frameQ;
    logic reqQ;
    logic weQ;
    logic adrQ;
    logic [7:0] datQ;

    task automatic compare(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            errorCount++;
            $display("Fail %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // A move key turns the player even when a bound blocks the step
    task automatic applyMove();
        bit moved;
        moved = 1'b0;
        if (key == spritePkg::keyUp)
        begin
            dir = spritePkg::dirUp;
            moved = y > spritePkg::screenYMin;
            y = moved ? y - spritePkg::stepY : y;
        end
        else if (key == spritePkg::keyDown)
        begin
            dir = spritePkg::dirDown;
            moved = y + spritePkg::spriteHeight < spritePkg::screenYMax;
            y = moved ? y + spritePkg::stepY : y;
        end
        else if (key == spritePkg::keyLeft)
        begin
            dir = spritePkg::dirLeft;
            moved = x > spritePkg::screenXMin;
            x = moved ? x - spritePkg::stepX : x;
        end
        else if (key == spritePkg::keyRight)
        begin
            dir = spritePkg::dirRight;
            moved = x + spritePkg::spriteWidth < spritePkg::screenXMax;
            x = moved ? x + spritePkg::stepX : x;
        end
        step = moved ? (step + 1) % 4 : 0;   // Standing still restarts the walk
    endtask

    always @(posedge Clk)
    begin
        if (reset)
        begin
            x = spritePkg::startX;
            y = spritePkg::startY;
            dir = spritePkg::dirDown;
            step = 0;
            key = 0;
            rises = 0;
            sinceRise = 99;
            expValid = 1'b0;
            reqQ = 1'b0;
            errorCount = 0;
        end
        else
        begin
            if (expValid)
            begin
                compare("objHit", expHit, objHit);
                compare("objAddr", expAddr, objAddr);
            end
            expHit = int'(pixelX) >= x && int'(pixelX) < x + spritePkg::spriteWidth &&
                     int'(pixelY) >= y && int'(pixelY) < y + spritePkg::spriteHeight;
            pose = 3 * dir + ((step % 2 == 1) ? 1 + step / 2 : 0);
            expAddr = expHit ? (int'(pixelX) - x) + (int'(pixelY) - y) * spritePkg::spriteWidth
                      + spritePkg::spriteWidth * spritePkg::spriteHeight * pose : 0;
            expValid = sinceRise >= 3;   // State settles a few clocks after a frame edge

            if (wbAck && !reqQ)
            begin
                errorCount++;
                $display("Bus acknowledge without a pending request at %0t", $time);
            end
            if (wbAck && weQ && adrQ == spritePkg::regKey)
                key = datQ;
            if (wbAck && !weQ && sinceRise >= 4)
                compare("wbDatR", adrQ ? (step << 20) | (dir << 18) | (y << 9) | x : key, wbDatR);
            reqQ = wbCyc && wbStb;
            weQ = wbWe;
            adrQ = wbAdr;
            datQ = wbDatW[7:0];

            if (sinceRise < 99)
                sinceRise++;
            if (frameClk && !frameQ)
            begin
                sinceRise = 0;
                rises = (rises + 1) % spritePkg::framesPerMove;
                if (rises == 0)
                    applyMove();
            end
        end
        frameQ = frameClk;
    end

endmodule

// ==== test/playerTb.sv ====
// Sprite player testbench
`timescale 1ns/1ps

module playerTb;

    logic        Clk;
    logic        reset;
    logic        frameClk = 1'b0;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic        wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic        wbAck;
    logic [8:0]  pixelX;
    logic [8:0]  pixelY;
    logic        objHit;
    logic [12:0] objAddr;
    logic [4:0]  framePhase = 5'd0;
    logic [31:0] lfsr = 32'h859d_2724;
    logic [31:0] lastRead;
    logic [7:0]  keys [4] = '{spritePkg::keyUp, spritePkg::keyDown,
                              spritePkg::keyLeft, spritePkg::keyRight};
    int          checkErrors;
    int          tbErrors = 0;

    playerTop dut0 (.*);

    playerChecker checker0 (.errorCount(checkErrors), .*);

    initial
    begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(negedge Clk)
    begin
        framePhase <= framePhase + 5'd1;
        if (framePhase == 5'd15 || framePhase == 5'd31)
            frameClk <= ~frameClk;   // Half period of 16 clocks
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic endRun();
        $display("Errors: %0d from checker, %0d from testbench", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    task automatic abortRun(input string why);
        $display("%s at %0t", why, $time);
        tbErrors++;
        endRun();
    endtask

    // Keeps clear of the move tick after each rising frame edge
    task automatic waitQuiet();
        int n;
        n = 0;
        @(negedge Clk);
        while (framePhase > 5'd11 && framePhase < 5'd19 && n < 20)
        begin
            @(negedge Clk);
            n++;
        end
        if (n == 20)
            abortRun("Timeout waiting for a quiet frame window");
    endtask

    task automatic waitFrames(input int count);
        int n;
        repeat (count)
        begin
            n = 0;
            @(negedge Clk);
            while (framePhase != 5'd16 && n < 40)
            begin
                @(negedge Clk);
                n++;
            end
            if (n == 40)
                abortRun("Timeout waiting for a frame edge");
        end
    endtask

    task automatic busCycle(input logic we, input logic adr, input logic [31:0] data);
        int n;
        waitQuiet();
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = data;
        n = 0;
        do
        begin
            @(negedge Clk);
            n++;
        end
        while (!wbAck && n < 20);
        if (!wbAck)
            abortRun("Timeout: no bus acknowledge");
        lastRead = wbDatR;
        wbCyc = 1'b0;   // Released as soon as the ack is seen
        wbStb = 1'b0;
    endtask

    task automatic drivePixel(input int px, input int py);
        waitQuiet();
        pixelX = px[8:0];
        pixelY = py[8:0];
    endtask

    task automatic sweepAround(input int x0, input int y0);
        for (int py = y0 - 2; py < y0 + spritePkg::spriteHeight + 2; py++)
            for (int px = x0 - 2; px < x0 + spritePkg::spriteWidth + 2; px++)
                drivePixel(px, py);
    endtask

    // One move with the given key and then a status read and a few pixels near the player
    task automatic stepWith(input logic [7:0] key);
        busCycle(1'b1, spritePkg::regKey, {24'b0, key});
        waitFrames(spritePkg::framesPerMove);
        busCycle(1'b0, spritePkg::regStatus, '0);
        repeat (4)
            drivePixel(int'(lastRead[8:0]) + int'(randBits(5)) - 6,
                       int'(lastRead[17:9]) + int'(randBits(5)) - 6);
    endtask

    initial
    begin
        reset = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = 1'b0;
        wbDatW = '0;
        pixelX = '0;
        pixelY = '0;
        repeat (4) @(negedge Clk);
        reset = 1'b0;

        busCycle(1'b0, spritePkg::regStatus, '0);
        sweepAround(spritePkg::startX, spritePkg::startY);
        busCycle(1'b1, spritePkg::regKey, randBits(32));
        busCycle(1'b0, spritePkg::regKey, '0);
        busCycle(1'b1, spritePkg::regStatus, 32'hffff_ffff);   // Ignored by the DUT
        busCycle(1'b0, spritePkg::regStatus, '0);
        busCycle(1'b0, spritePkg::regKey, '0);

        for (int i = 0; i < 60; i++)
        begin
            if (randBits(3) == 0)
                stepWith(8'(randBits(8)));   // Mostly unknown keys
            else
                stepWith(keys[2'(randBits(2))]);
            if (i % 20 == 10)
                sweepAround(int'(lastRead[8:0]), int'(lastRead[17:9]));
        end

        // Each run is long enough to reach its bound from anywhere on screen
        repeat (160) stepWith(spritePkg::keyRight);
        repeat (120) stepWith(spritePkg::keyDown);
        sweepAround(int'(lastRead[8:0]), int'(lastRead[17:9]));
        repeat (160) stepWith(spritePkg::keyLeft);
        repeat (120) stepWith(spritePkg::keyUp);
        stepWith(8'h55);
        sweepAround(int'(lastRead[8:0]), int'(lastRead[17:9]));
        endRun();
    end

endmodule

// ==== filelist.f ====
verilog/spritePkg.sv
verilog/playerStateIf.sv
verilog/frameTick.sv
verilog/playerMotion.sv
verilog/spriteAddrGen.sv
verilog/wbKeyPort.sv
verilog/playerTop.sv
test/playerChecker.sv
test/playerTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the sprite player testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module playerTb \
        -f filelist.f -o playerSim > build.log 2>&1 \
    && ./obj_dir/playerSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
